/* logic/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  localparam logic [31:0] CLK_FREQ  = 32'd50_000_000;  // System clock in Hz
  localparam logic [31:0] SPI_SPEED = 32'd8_000_000;   // Target serial clock in Hz

  // System clocks per half sclk period, rounded down and never below one
  localparam logic [31:0] SCLK_HALF_RAW = CLK_FREQ / (32'd2 * SPI_SPEED);
  localparam logic [31:0] SCLK_HALF_DIV = (SCLK_HALF_RAW < 32'd1) ? 32'd1 : SCLK_HALF_RAW;

  localparam int unsigned SCLK_CNT_W = $clog2(SCLK_HALF_DIV + 32'd1);  // Half-period counter
  localparam logic [SCLK_CNT_W-1:0] SCLK_RELOAD = SCLK_CNT_W'(SCLK_HALF_DIV - 32'd1);

  localparam int unsigned SPI_BITS   = 8;             // Bits per transfer
  localparam int unsigned XFER_EDGES = 2 * SPI_BITS;  // Lead plus trail per bit
  localparam int unsigned EDGE_CNT_W = $clog2(XFER_EDGES);

  // Configuration byte layout
  localparam int unsigned CONF_CPHA_BIT = 0;
  localparam int unsigned CONF_CPOL_BIT = 1;

  typedef enum logic [0:0] {
    REG_DATA = 1'b0,  // Byte out on write, byte in on read
    REG_CTRL = 1'b1   // Selects, conf, indicators and status
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_IDLE     = 2'b00,
    ST_BUSY     = 2'b01,
    ST_COMPLETE = 2'b10,  // Received byte waiting for the host
    ST_RELEASE  = 2'b11   // Byte read, waiting for an idle bus cycle
  } spi_state_e;

endpackage

`default_nettype wire

/* logic/spi_sclk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic lead,
  output logic trail
);

  import spi_pkg::*;

  logic [SCLK_CNT_W-1:0] half_cnt;
  logic                  phase;     // Low before a leading edge, high before a trailing one
  logic                  boundary;

  // Half period ends when the down counter reaches zero
  assign boundary = run && (half_cnt == '0);

  assign lead  = boundary && !phase;
  assign trail = boundary && phase;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt <= SCLK_RELOAD;
      phase    <= 1'b0;
    end else if (!run) begin
      half_cnt <= SCLK_RELOAD;  // Same alignment at every transfer start
      phase    <= 1'b0;
    end else if (boundary) begin
      half_cnt <= SCLK_RELOAD;
      phase    <= ~phase;
    end else begin
      half_cnt <= half_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/spi_xcvr.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_xcvr (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] conf,
  input  logic       start,
  input  logic [7:0] tx_byte,
  output logic [7:0] rx_byte,
  output logic       done,
  input  logic       miso,
  output logic       mosi,
  output logic       sclk
);

  import spi_pkg::*;

  logic                  run;
  logic                  lead;
  logic                  trail;
  logic                  cpha;
  logic                  cpol;
  logic                  edge_stb;
  logic                  shift_stb;
  logic                  sample_stb;
  logic                  last_edge;
  logic                  load;
  logic                  finish;
  logic [EDGE_CNT_W-1:0] edge_cnt;
  logic [7:0]            tx_sr;
  logic [7:0]            rx_sr;
  logic                  sclk_q;
  logic                  mosi_q;

  assign cpha = conf[CONF_CPHA_BIT];
  assign cpol = conf[CONF_CPOL_BIT];

  assign edge_stb   = lead | trail;
  assign shift_stb  = cpha ? lead : trail;   // Phase 1 drives data on the leading edge
  assign sample_stb = cpha ? trail : lead;
  assign last_edge  = (edge_cnt == EDGE_CNT_W'(XFER_EDGES - 1));
  assign load       = start && !run;

  spi_sclk_gen u_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .lead  (lead),
    .trail (trail)
  );

  // Transfer sequencing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run      <= 1'b0;
      edge_cnt <= '0;
      finish   <= 1'b0;
      done     <= 1'b0;
    end else begin
      done   <= finish;  // One cycle after the last trailing edge
      finish <= 1'b0;
      if (load) begin
        run      <= 1'b1;
        edge_cnt <= '0;
      end else if (run && edge_stb) begin
        edge_cnt <= edge_cnt + 1'b1;
        if (last_edge) begin
          run    <= 1'b0;
          finish <= 1'b1;
        end
      end
    end
  end

  // Shift registers and pins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_sr  <= 8'h00;
      rx_sr  <= 8'h00;
      sclk_q <= 1'b0;
      mosi_q <= 1'b0;
    end else if (load) begin
      sclk_q <= cpol;
      if (cpha) begin
        tx_sr <= tx_byte;
      end else begin
        tx_sr  <= {tx_byte[6:0], 1'b0};
        mosi_q <= tx_byte[7];  // MSB must be valid before the first leading edge
      end
    end else if (run) begin
      if (edge_stb)
        sclk_q <= ~sclk_q;
      if (shift_stb) begin
        mosi_q <= tx_sr[7];
        tx_sr  <= {tx_sr[6:0], 1'b0};
      end
      if (sample_stb)
        rx_sr <= {rx_sr[6:0], miso};
    end else begin
      sclk_q <= cpol;  // Idle level follows polarity
      mosi_q <= 1'b0;
    end
  end

  assign sclk    = sclk_q;
  assign mosi    = mosi_q;
  assign rx_byte = rx_sr;

endmodule

`default_nettype wire

/* logic/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        read,
  input  logic        write,
  input  logic        address,
  input  logic [3:0]  be,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  input  logic        wp_n,
  output logic [7:0]  selects,
  output logic [1:0]  itd,
  output logic [7:0]  conf,
  output logic        start,
  output logic [7:0]  tx_byte,
  input  logic [7:0]  rx_byte,
  input  logic        done
);

  import spi_pkg::*;

  spi_state_e state;
  spi_state_e state_next;
  reg_addr_e  addr;
  logic       bus_wr;
  logic       bus_rd;
  logic       bus_idle;
  logic       data_wr;
  logic       data_rd;
  logic       ctrl_wr;
  logic [7:0] rx_q;

  assign addr     = reg_addr_e'(address);
  assign bus_wr   = write && !read;
  assign bus_rd   = read && !write;
  assign bus_idle = !read && !write;

  // Only a byte-enabled data write in idle launches a transfer
  assign data_wr = bus_wr && (addr == REG_DATA) && be[0] && (state == ST_IDLE);
  assign data_rd = bus_rd && (addr == REG_DATA);
  assign ctrl_wr = bus_wr && (addr == REG_CTRL);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (data_wr)
          state_next = ST_BUSY;
      end
      ST_BUSY: begin
        if (done)
          state_next = ST_COMPLETE;
      end
      ST_COMPLETE: begin
        if (data_rd)
          state_next = ST_RELEASE;
      end
      ST_RELEASE: begin
        if (bus_idle)
          state_next = ST_IDLE;  // Ready drops only after the read strobe ends
      end
      default: state_next = ST_IDLE;
    endcase
  end

  // Transfer state, request and byte registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      start   <= 1'b0;
      tx_byte <= 8'h00;
      rx_q    <= 8'h00;
    end else begin
      state <= state_next;
      start <= data_wr;  // Pulse lines up with the stored byte
      if (data_wr)
        tx_byte <= data_in[7:0];
      if (done && (state == ST_BUSY))
        rx_q <= rx_byte;
    end
  end

  // Control register fields, each under its own byte enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      selects <= 8'hff;  // All slaves deselected
      conf    <= 8'h00;
      itd     <= 2'b00;
    end else if (ctrl_wr) begin
      if (be[3])
        selects <= data_in[31:24];
      if (be[2])
        conf <= data_in[23:16];
      if (be[1])
        itd <= data_in[9:8];
    end
  end

  // Read mux
  always_comb begin
    data_out = 32'h0000_0000;
    if (bus_rd) begin
      case (addr)
        REG_DATA: data_out = {24'h00_0000, rx_q};
        REG_CTRL: data_out = {selects, conf, 6'b000000, itd, 5'b00000, ~wp_n,
                              (state != ST_BUSY), (state == ST_COMPLETE)};
        default:  data_out = 32'h0000_0000;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/spi_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_periph_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        read,
  input  logic        write,
  input  logic        address,
  input  logic [3:0]  be,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  input  logic        miso,
  output logic        mosi,
  output logic        sclk,
  output logic [7:0]  selects,
  input  logic        wp_n,
  output logic [1:0]  itd
);

  logic [7:0] conf;
  logic       xfer_start;
  logic [7:0] xfer_byte;
  logic [7:0] rx_byte;
  logic       xfer_done;

  spi_master u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .read     (read),
    .write    (write),
    .address  (address),
    .be       (be),
    .data_in  (data_in),
    .data_out (data_out),
    .wp_n     (wp_n),
    .selects  (selects),
    .itd      (itd),
    .conf     (conf),
    .start    (xfer_start),
    .tx_byte  (xfer_byte),
    .rx_byte  (rx_byte),
    .done     (xfer_done)
  );

  spi_xcvr u_xcvr (
    .clk     (clk),
    .rst_n   (rst_n),
    .conf    (conf),
    .start   (xfer_start),
    .tx_byte (xfer_byte),
    .rx_byte (rx_byte),
    .done    (xfer_done),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk)
  );

endmodule

`default_nettype wire

/* tb/tb_spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave (
  input  logic       sclk,
  input  logic       mosi,
  input  logic       cs_n,
  input  logic [1:0] mode,     // Same bit positions as the configuration byte
  input  logic [7:0] reply,
  output logic       miso,
  output logic [7:0] rx_data,
  output int         bit_cnt
);

  import spi_pkg::*;

  logic [7:0] tx_sr;
  logic       leading;

  initial begin
    miso    = 1'b0;
    rx_data = 8'h00;
    bit_cnt = 0;
    tx_sr   = 8'h00;
    leading = 1'b0;
  end

  // New frame on select
  always @(negedge cs_n) begin
    rx_data = 8'h00;
    bit_cnt = 0;
    tx_sr   = reply;
    if (!mode[CONF_CPHA_BIT]) begin
      miso  = tx_sr[7];  // First bit ahead of the leading edge
      tx_sr = {tx_sr[6:0], 1'b0};
    end
  end

  always @(sclk) begin
    if (cs_n === 1'b0 && (sclk === 1'b0 || sclk === 1'b1)) begin
      leading = (sclk != mode[CONF_CPOL_BIT]);
      if (leading != mode[CONF_CPHA_BIT]) begin
        rx_data = {rx_data[6:0], mosi};  // Sampling edge
        bit_cnt = bit_cnt + 1;
      end else begin
        miso  = tx_sr[7];  // Shifting edge
        tx_sr = {tx_sr[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_spi_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_periph;

  import spi_pkg::*;

  localparam int CLK_HALF  = 20;
  localparam int XFER_CLKS = 2 * SPI_BITS * SCLK_HALF_DIV + 2;  // Start to done
  localparam int BUS_CLKS  = 60;                               // Register traffic per transfer
  localparam int WDOG_NS   = 20 * (XFER_CLKS + BUS_CLKS) * 2 * CLK_HALF + 20_000;

  logic        clk;
  logic        rst_n;
  logic        read;
  logic        write;
  logic        address;
  logic [3:0]  be;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        miso;
  logic        mosi;
  logic        sclk;
  logic [7:0]  selects;
  logic        wp_n;
  logic [1:0]  itd;
  logic [1:0]  slave_mode;
  logic [7:0]  slave_reply;
  logic [7:0]  slave_rx;
  int          slave_bits;
  logic [31:0] rng_state;
  logic [7:0]  exp_sel;   // Expected register contents
  logic [7:0]  exp_conf;
  logic [1:0]  exp_itd;
  logic        exp_wp;
  int          checks;
  int          errors;

  spi_periph_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .read     (read),
    .write    (write),
    .address  (address),
    .be       (be),
    .data_in  (data_in),
    .data_out (data_out),
    .miso     (miso),
    .mosi     (mosi),
    .sclk     (sclk),
    .selects  (selects),
    .wp_n     (wp_n),
    .itd      (itd)
  );

  tb_spi_slave u_slave (
    .sclk    (sclk),
    .mosi    (mosi),
    .cs_n    (selects[0]),
    .mode    (slave_mode),
    .reply   (slave_reply),
    .miso    (miso),
    .rx_data (slave_rx),
    .bit_cnt (slave_bits)
  );

  initial clk = 1'b0;
  always #(CLK_HALF) clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Control register layout from the top byte down
  function automatic logic [31:0] ctrl_word(input logic tx_rdy, input logic rx_rdy);
    return {exp_sel, exp_conf, 6'b000000, exp_itd, 5'b00000, exp_wp, tx_rdy, rx_rdy};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("ERROR: %s = 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [3:0] byte_en,
                           input logic [31:0] value);
    @(posedge clk);
    write   <= 1'b1;
    address <= addr;
    be      <= byte_en;
    data_in <= value;
    @(posedge clk);
    write <= 1'b0;
    be    <= 4'b0000;
  endtask

  task automatic read_reg(input reg_addr_e addr, output logic [31:0] value);
    @(posedge clk);
    read    <= 1'b1;
    address <= addr;
    @(negedge clk);
    value = data_out;  // Read mux settled mid-cycle
    @(posedge clk);
    read <= 1'b0;
  endtask

  task automatic read_reg_expect(input reg_addr_e addr, input logic [31:0] expected);
    logic [31:0] value;
    read_reg(addr, value);
    check_value((addr == REG_CTRL) ? "data_out (ctrl)" : "data_out (data)", value, expected);
  endtask

  task automatic wait_rx_ready();
    logic [31:0] status;
    int          polls;
    status = 32'h0000_0000;
    polls  = 0;
    while (!status[0] && polls < XFER_CLKS) begin
      read_reg(REG_CTRL, status);
      polls++;
      if (!status[0])
        check_value("data_out[1] tx ready", status[1], 1'b0);  // Busy until done
    end
    assert (status[0]) else begin
      errors++;
      $display("Receive ready did not rise within %0d status reads", polls);
    end
  endtask

  // Deselect, set the mode, then select slave 0
  task automatic select_mode(input logic cpol, input logic cpha);
    logic [7:0] conf_byte;
    conf_byte = 8'h00;
    conf_byte[CONF_CPOL_BIT] = cpol;
    conf_byte[CONF_CPHA_BIT] = cpha;
    write_reg(REG_CTRL, 4'b1000, 32'hFF00_0000);
    slave_mode = conf_byte[1:0];
    write_reg(REG_CTRL, 4'b0100, {8'h00, conf_byte, 16'h0000});
    write_reg(REG_CTRL, 4'b1000, 32'hFE00_0000);
    exp_sel  = 8'hFE;
    exp_conf = conf_byte;
    @(negedge clk);
    check_value("sclk", sclk, cpol);  // Idle level before the transfer
  endtask

  task automatic exchange_byte(input logic cpol, input logic cpha, input logic [7:0] tx,
                               input logic [7:0] reply, input logic write_while_busy);
    slave_reply = reply;
    select_mode(cpol, cpha);
    write_reg(REG_DATA, 4'b0001, {24'h00_0000, tx});
    read_reg_expect(REG_CTRL, ctrl_word(1'b0, 1'b0));
    if (write_while_busy)
      write_reg(REG_DATA, 4'b0001, {24'h00_0000, ~tx});  // Must be dropped
    wait_rx_ready();
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b1));
    read_reg_expect(REG_DATA, {24'h00_0000, reply});
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));  // Ready cleared after an idle cycle
    @(negedge clk);
    check_value("slave_rx", slave_rx, tx);
    check_value("slave_bits", slave_bits, 8);
    check_value("sclk", sclk, cpol);
    write_reg(REG_CTRL, 4'b1000, 32'hFF00_0000);
    exp_sel = 8'hFF;
  endtask

  // Data read followed at once by a data write that lands in ST_RELEASE
  task automatic read_then_write(input logic [7:0] expected, input logic [7:0] wr_byte);
    logic [31:0] value;
    @(posedge clk);
    read    <= 1'b1;
    address <= REG_DATA;
    @(negedge clk);
    value = data_out;
    @(posedge clk);
    read    <= 1'b0;
    write   <= 1'b1;
    be      <= 4'b0001;
    data_in <= {24'h00_0000, wr_byte};
    @(posedge clk);
    write <= 1'b0;
    be    <= 4'b0000;
    check_value("data_out (data)", value, {24'h00_0000, expected});
  endtask

  task automatic test_reset_state();
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    @(negedge clk);
    check_value("sclk", sclk, 1'b0);
    check_value("selects", selects, 8'hFF);
    check_value("mosi", mosi, 1'b0);
  endtask

  task automatic test_ctrl_writes();
    write_reg(REG_CTRL, 4'b1000, 32'hA73C_02FF);
    exp_sel = 8'hA7;
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    write_reg(REG_CTRL, 4'b0100, 32'h113C_03FF);  // Phase and polarity stay 0
    exp_conf = 8'h3C;
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    write_reg(REG_CTRL, 4'b0010, 32'h2255_02FF);
    exp_itd = 2'b10;
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    write_reg(REG_CTRL, 4'b0001, 32'hFFFF_FFFF);  // No field behind be[0]
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    @(negedge clk);
    check_value("selects", selects, exp_sel);
    check_value("itd", itd, exp_itd);
    @(posedge clk);
    wp_n <= 1'b0;
    exp_wp = 1'b1;
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    wp_n <= 1'b1;
    exp_wp = 1'b0;
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
  endtask

  task automatic test_all_modes();
    logic [31:0] r;
    for (int m = 0; m < 4; m++) begin
      r = next_random();
      exchange_byte(m[1], m[0], r[7:0], r[15:8], 1'b0);
    end
  endtask

  task automatic test_ignored_writes();
    logic [31:0] r;
    r = next_random();
    exchange_byte(1'b0, 1'b0, r[7:0], r[15:8], 1'b1);
    slave_reply = r[23:16];
    select_mode(1'b0, 1'b0);
    write_reg(REG_DATA, 4'b1110, {24'hFF_FFFF, r[7:0]});
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    repeat (XFER_CLKS) @(posedge clk);
    check_value("slave_bits", slave_bits, 0);
    write_reg(REG_DATA, 4'b0001, {24'h00_0000, r[31:24]});
    wait_rx_ready();
    read_then_write(r[23:16], ~r[31:24]);
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    repeat (XFER_CLKS) @(posedge clk);
    @(negedge clk);
    check_value("slave_rx", slave_rx, r[31:24]);
    check_value("slave_bits", slave_bits, 8);
    read_reg_expect(REG_CTRL, ctrl_word(1'b1, 1'b0));
    write_reg(REG_CTRL, 4'b1000, 32'hFF00_0000);
    exp_sel = 8'hFF;
  endtask

  initial begin
    rst_n       = 1'b0;
    read        = 1'b0;
    write       = 1'b0;
    address     = 1'b0;
    be          = 4'b0000;
    data_in     = 32'h0000_0000;
    wp_n        = 1'b1;
    slave_mode  = 2'b00;
    slave_reply = 8'h00;
    rng_state   = 32'h5567_93a1;
    exp_sel     = 8'hFF;
    exp_conf    = 8'h00;
    exp_itd     = 2'b00;
    exp_wp      = 1'b0;
    checks      = 0;
    errors      = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_ctrl_writes();
    exchange_byte(1'b0, 1'b0, 8'hC5, 8'h5A, 1'b0);  // Mode 0 with fixed bytes
    test_all_modes();
    test_ignored_writes();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog
  initial begin
    #(WDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WDOG_NS);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* spi_periph.f */
logic/spi_pkg.sv
logic/spi_sclk_gen.sv
logic/spi_xcvr.sv
logic/spi_master.sv
logic/spi_periph_top.sv
tb/tb_spi_slave.sv
tb/tb_spi_periph.sv
